/* hw/conv_pkg.sv */
package conv_pkg;

  localparam int PIXEL_W     = 8;
  localparam int COEF_W      = 8;
  localparam int TAPS        = 25;
  localparam int PROD_W      = 16;
  // Holds 25 * 255 * 255 without loss
  localparam int SUM_W       = 21;
  localparam int TREE_STAGES = 5;

  typedef logic [PIXEL_W-1:0] pixel_t;
  typedef logic [COEF_W-1:0]  coef_t;
  typedef logic [PROD_W-1:0]  prod_t;
  typedef logic [SUM_W-1:0]   sum_t;

  // Element 0 is the oldest row
  typedef pixel_t [4:0] column_t;

  // Element r*5+c is row r, column c
  typedef pixel_t [TAPS-1:0] window_t;

  typedef prod_t [TAPS-1:0] prod_vec_t;

  // Same tap numbering as window_t
  typedef struct packed {
    logic [4:0] idx;
    coef_t      coef;
  } kernel_wr_t;

endpackage

/* hw/line_buffer.sv */
`timescale 1ns/1ns

module line_buffer #(
  parameter int IMG_WIDTH = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              advance,
  input  logic              shift,
  input  conv_pkg::pixel_t  pix,
  output conv_pkg::column_t col
);

  localparam int PTR_W = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;

  // Row 0 holds the previous line and row 3 the oldest
  conv_pkg::pixel_t rows [4][IMG_WIDTH];

  logic [PTR_W-1:0] ptr;
  logic             wr_en;

  assign wr_en = shift & advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (wr_en) begin
      if (ptr == PTR_W'(IMG_WIDTH - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // Each row cascades into the next older one at the same column
  always_ff @(posedge clk) begin
    if (wr_en) begin
      rows[0][ptr] <= pix;
      for (int r = 1; r < 4; r++) begin
        rows[r][ptr] <= rows[r-1][ptr];
      end
    end
  end

  // Oldest row first, current pixel last
  always_comb begin
    for (int r = 0; r < 4; r++) begin
      col[r] = rows[3-r][ptr];
    end
    col[4] = pix;
  end

  ptr_in_range: assert property (
    @(posedge clk) disable iff (rst)
    int'(ptr) < IMG_WIDTH
  );

endmodule

/* hw/window_gen.sv */
`timescale 1ns/1ns

module window_gen #(
  parameter int IMG_WIDTH  = 16,
  parameter int IMG_HEIGHT = 12
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              advance,
  input  logic              pix_valid,
  input  conv_pkg::pixel_t  pix_data,
  output logic              win_valid,
  output conv_pkg::window_t win
);

  localparam int COL_W = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;
  localparam int ROW_W = (IMG_HEIGHT > 1) ? $clog2(IMG_HEIGHT) : 1;

  logic [COL_W-1:0]  col_cnt;
  logic [ROW_W-1:0]  row_cnt;
  logic              xfer;
  logic              in_image;
  conv_pkg::column_t col;

  assign xfer = pix_valid & advance;

  // Bottom-right pixel of a complete window
  assign in_image = (col_cnt >= COL_W'(4)) && (row_cnt >= ROW_W'(4));

  line_buffer #(
    .IMG_WIDTH(IMG_WIDTH)
  ) u_line_buffer (
    .clk     (clk),
    .rst     (rst),
    .advance (advance),
    .shift   (pix_valid),
    .pix     (pix_data),
    .col     (col)
  );

  // Raster position, wraps to the next frame
  always_ff @(posedge clk) begin
    if (rst) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (xfer) begin
      if (col_cnt == COL_W'(IMG_WIDTH - 1)) begin
        col_cnt <= '0;
        if (row_cnt == ROW_W'(IMG_HEIGHT - 1)) begin
          row_cnt <= '0;
        end else begin
          row_cnt <= row_cnt + 1'b1;
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      win_valid <= 1'b0;
    end else if (advance) begin
      win_valid <= xfer & in_image;
    end
  end

  // Columns move left, the new one enters at column 4
  always_ff @(posedge clk) begin
    if (xfer) begin
      for (int r = 0; r < 5; r++) begin
        for (int c = 0; c < 4; c++) begin
          win[r*5 + c] <= win[r*5 + c + 1];
        end
        win[r*5 + 4] <= col[r];
      end
    end
  end

endmodule

/* hw/conv_mac_array.sv */
`timescale 1ns/1ns

module conv_mac_array (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 advance,
  input  logic                 kernel_wr_valid,
  input  conv_pkg::kernel_wr_t kernel_wr,
  input  logic                 win_valid,
  input  conv_pkg::window_t    win,
  output logic                 prod_valid,
  output conv_pkg::prod_vec_t  prod
);

  conv_pkg::coef_t kern [conv_pkg::TAPS];

  // Coefficient bank, writes are never held off
  always_ff @(posedge clk) begin
    if (kernel_wr_valid) begin
      kern[kernel_wr.idx] <= kernel_wr.coef;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prod_valid <= 1'b0;
    end else if (advance) begin
      prod_valid <= win_valid;
    end
  end

  // 8x8 unsigned, full 16-bit product
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < conv_pkg::TAPS; i++) begin
        prod[i] <= conv_pkg::prod_t'(win[i]) * conv_pkg::prod_t'(kern[i]);
      end
    end
  end

  kernel_idx_in_range: assert property (
    @(posedge clk) disable iff (rst)
    kernel_wr_valid |-> (kernel_wr.idx < 5'(conv_pkg::TAPS))
  );

endmodule

/* hw/adder_tree.sv */
`timescale 1ns/1ns

module adder_tree (
  input  logic                clk,
  input  logic                rst,
  input  logic                prod_valid,
  input  conv_pkg::prod_vec_t prod,
  input  logic                res_ready,
  output logic                res_valid,
  output conv_pkg::sum_t      res_data,
  output logic                advance
);

  // Valid bit per level, the last one is the output register
  logic [conv_pkg::TREE_STAGES-1:0] stage_valid;

  conv_pkg::sum_t lvl1 [13];
  conv_pkg::sum_t lvl2 [7];
  conv_pkg::sum_t lvl3 [4];
  conv_pkg::sum_t lvl4 [2];

  assign res_valid = stage_valid[conv_pkg::TREE_STAGES-1];
  // Stall everything only when a result is waiting and not taken
  assign advance   = ~res_valid | res_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= '0;
    end else if (advance) begin
      stage_valid <= {stage_valid[conv_pkg::TREE_STAGES-2:0], prod_valid};
    end
  end

  // 25 -> 13 -> 7 -> 4 -> 2 -> 1, odd element passes through
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < 12; i++) begin
        lvl1[i] <= conv_pkg::sum_t'(prod[2*i]) + conv_pkg::sum_t'(prod[2*i + 1]);
      end
      lvl1[12] <= conv_pkg::sum_t'(prod[24]);

      for (int i = 0; i < 6; i++) begin
        lvl2[i] <= lvl1[2*i] + lvl1[2*i + 1];
      end
      lvl2[6] <= lvl1[12];

      for (int i = 0; i < 3; i++) begin
        lvl3[i] <= lvl2[2*i] + lvl2[2*i + 1];
      end
      lvl3[3] <= lvl2[6];

      lvl4[0] <= lvl3[0] + lvl3[1];
      lvl4[1] <= lvl3[2] + lvl3[3];

      res_data <= lvl4[0] + lvl4[1];
    end
  end

  res_hold: assert property (
    @(posedge clk) disable iff (rst)
    (res_valid && !res_ready) |=> (res_valid && $stable(res_data))
  );

endmodule

/* hw/conv5x5_top.sv */
`timescale 1ns/1ns

module conv5x5_top #(
  parameter int IMG_WIDTH  = 16,
  parameter int IMG_HEIGHT = 12
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 pix_valid,
  output logic                 pix_ready,
  input  conv_pkg::pixel_t     pix_data,
  input  logic                 kernel_wr_valid,
  input  conv_pkg::kernel_wr_t kernel_wr,
  output logic                 res_valid,
  input  logic                 res_ready,
  output conv_pkg::sum_t       res_data
);

  logic                advance;
  logic                win_valid;
  conv_pkg::window_t   win;
  logic                prod_valid;
  conv_pkg::prod_vec_t prod;

  assign pix_ready = advance;

  window_gen #(
    .IMG_WIDTH  (IMG_WIDTH),
    .IMG_HEIGHT (IMG_HEIGHT)
  ) u_window_gen (
    .clk       (clk),
    .rst       (rst),
    .advance   (advance),
    .pix_valid (pix_valid),
    .pix_data  (pix_data),
    .win_valid (win_valid),
    .win       (win)
  );

  conv_mac_array u_conv_mac_array (
    .clk             (clk),
    .rst             (rst),
    .advance         (advance),
    .kernel_wr_valid (kernel_wr_valid),
    .kernel_wr       (kernel_wr),
    .win_valid       (win_valid),
    .win             (win),
    .prod_valid      (prod_valid),
    .prod            (prod)
  );

  adder_tree u_adder_tree (
    .clk        (clk),
    .rst        (rst),
    .prod_valid (prod_valid),
    .prod       (prod),
    .res_ready  (res_ready),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .advance    (advance)
  );

endmodule

/* bench/tb_conv5x5.sv */
`timescale 1ns/1ns

module tb_conv5x5;

  localparam int IMG_W         = 16;
  localparam int IMG_H         = 12;
  localparam int WIN_PER_FRAME = (IMG_W - 4) * (IMG_H - 4);
  localparam int STALL_LIMIT   = 200;
  localparam int DRAIN_LIMIT   = 4000;
  localparam int SETTLE_CYCLES = 16;

  logic                 clk;
  logic                 rst;
  logic                 pix_valid;
  logic                 pix_ready;
  conv_pkg::pixel_t     pix_data;
  logic                 kernel_wr_valid;
  conv_pkg::kernel_wr_t kernel_wr;
  logic                 res_valid;
  logic                 res_ready = 1'b1;
  conv_pkg::sum_t       res_data;

  conv_pkg::pixel_t img [IMG_H][IMG_W];
  conv_pkg::coef_t  kern [conv_pkg::TAPS];
  conv_pkg::sum_t   exp_q [$];

  int             error_count;
  int             result_count;
  bit             bp_on;
  bit             was_stalled;
  conv_pkg::sum_t held_data;

  conv5x5_top #(
    .IMG_WIDTH  (IMG_W),
    .IMG_HEIGHT (IMG_H)
  ) u_dut (
    .clk             (clk),
    .rst             (rst),
    .pix_valid       (pix_valid),
    .pix_ready       (pix_ready),
    .pix_data        (pix_data),
    .kernel_wr_valid (kernel_wr_valid),
    .kernel_wr       (kernel_wr),
    .res_valid       (res_valid),
    .res_ready       (res_ready),
    .res_data        (res_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_sum(input string name, input conv_pkg::sum_t got,
                           input conv_pkg::sum_t exp);
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Sampled at negedge, a transfer completes on the next rising edge
  task automatic collect_results();
    conv_pkg::sum_t expected;
    forever begin
      @(negedge clk);
      if (was_stalled) begin
        check_bit("res_valid", res_valid, 1'b1);
        check_sum("res_data", res_data, held_data);
      end
      was_stalled = res_valid && !res_ready;
      held_data   = res_data;
      if (res_valid && res_ready) begin
        result_count++;
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Result 0x%0h arrived when none was expected", res_data);
        end else begin
          expected = exp_q.pop_front();
          check_sum("res_data", res_data, expected);
        end
      end
    end
  endtask

  task automatic drive_res_ready();
    forever begin
      @(posedge clk);
      res_ready <= bp_on ? ($urandom_range(2) != 0) : 1'b1;
    end
  endtask

  // Reference model, sum of tap i pixel times coefficient i
  function automatic void expect_frame();
    int acc;
    for (int r = 4; r < IMG_H; r++) begin
      for (int c = 4; c < IMG_W; c++) begin
        acc = 0;
        for (int i = 0; i < conv_pkg::TAPS; i++) begin
          acc += int'(img[r - 4 + i / 5][c - 4 + i % 5]) * int'(kern[i]);
        end
        exp_q.push_back(conv_pkg::sum_t'(acc));
      end
    end
  endfunction

  // Impulse at tap 12 picks the pixel two rows up, two columns left
  function automatic void expect_impulse();
    for (int r = 4; r < IMG_H; r++) begin
      for (int c = 4; c < IMG_W; c++) begin
        exp_q.push_back(conv_pkg::sum_t'(img[r - 2][c - 2]));
      end
    end
  endfunction

  function automatic void fill_image(input bit rnd, input conv_pkg::pixel_t value);
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        img[r][c] = rnd ? conv_pkg::pixel_t'($urandom) : value;
      end
    end
  endfunction

  function automatic void random_kernel();
    for (int i = 0; i < conv_pkg::TAPS; i++) begin
      kern[i] = conv_pkg::coef_t'($urandom);
    end
  endfunction

  task automatic load_kernel();
    for (int i = 0; i < conv_pkg::TAPS; i++) begin
      kernel_wr_valid <= 1'b1;
      kernel_wr.idx   <= 5'(i);
      kernel_wr.coef  <= kern[i];
      @(posedge clk);
    end
    kernel_wr_valid <= 1'b0;
  endtask

  task automatic push_pixel(input conv_pkg::pixel_t p);
    int waited;
    bit taken;
    // Random idle cycle before the transfer
    if ($urandom_range(3) == 0) begin
      pix_valid <= 1'b0;
      @(posedge clk);
    end
    pix_valid <= 1'b1;
    pix_data  <= p;
    waited = 0;
    taken  = 1'b0;
    while (!taken && waited < STALL_LIMIT) begin
      @(negedge clk);
      taken = pix_ready;
      @(posedge clk);
      waited++;
    end
    if (!taken) begin
      error_count++;
      $display("Pixel input was not ready for %0d cycles", STALL_LIMIT);
    end
  endtask

  task automatic send_frame();
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        push_pixel(img[r][c]);
      end
    end
    pix_valid <= 1'b0;
  endtask

  task automatic finish_frame(input int start_count);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      error_count++;
      $display("Timed out with %0d results still missing", exp_q.size());
      exp_q.delete();
    end
    // Pipeline is 7 deep, stray extra results surface well within this
    waited = 0;
    while (waited < SETTLE_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (result_count - start_count != WIN_PER_FRAME) begin
      error_count++;
      $display("Frame gave %0d results instead of %0d",
               result_count - start_count, WIN_PER_FRAME);
    end
  endtask

  task automatic run_frame(input bit impulse);
    int start_count;
    start_count = result_count;
    if (impulse) begin
      expect_impulse();
    end else begin
      expect_frame();
    end
    send_frame();
    finish_frame(start_count);
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_bit("res_valid", res_valid, 1'b0);
    check_bit("pix_ready", pix_ready, 1'b1);
    @(posedge clk);
  endtask

  task automatic test_impulse();
    for (int i = 0; i < conv_pkg::TAPS; i++) begin
      kern[i] = (i == 12) ? 8'd1 : 8'd0;
    end
    load_kernel();
    fill_image(1'b1, 8'd0);
    run_frame(1'b1);
  endtask

  task automatic test_random();
    random_kernel();
    load_kernel();
    fill_image(1'b1, 8'd0);
    run_frame(1'b0);
  endtask

  task automatic test_backpressure();
    bp_on = 1'b1;
    random_kernel();
    load_kernel();
    fill_image(1'b1, 8'd0);
    run_frame(1'b0);
    bp_on = 1'b0;
  endtask

  task automatic test_all_max();
    int start_count;
    for (int i = 0; i < conv_pkg::TAPS; i++) begin
      kern[i] = 8'd255;
    end
    load_kernel();
    fill_image(1'b0, 8'd255);
    start_count = result_count;
    for (int n = 0; n < WIN_PER_FRAME; n++) begin
      exp_q.push_back(21'd1625625);
    end
    send_frame();
    finish_frame(start_count);
  endtask

  task automatic test_kernel_reload();
    random_kernel();
    load_kernel();
    fill_image(1'b1, 8'd0);
    run_frame(1'b0);
    random_kernel();
    load_kernel();
    fill_image(1'b1, 8'd0);
    run_frame(1'b0);
  endtask

  initial begin
    void'($urandom(37069));
    rst             = 1'b1;
    pix_valid       = 1'b0;
    pix_data        = '0;
    kernel_wr_valid = 1'b0;
    kernel_wr       = '0;
    error_count     = 0;
    result_count    = 0;
    bp_on           = 1'b0;
    was_stalled     = 1'b0;
    held_data       = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    fork
      drive_res_ready();
      collect_results();
    join_none

    test_reset();
    test_impulse();
    test_random();
    test_backpressure();
    test_all_max();
    test_kernel_reload();

    $display("Finished with %0d errors over %0d results", error_count, result_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
hw/conv_pkg.sv
hw/line_buffer.sv
hw/window_gen.sv
hw/conv_mac_array.sv
hw/adder_tree.sv
hw/conv5x5_top.sv
bench/tb_conv5x5.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_conv5x5
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard hw/*.sv bench/*.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
